/* logic/pwm_config.svh */
// global sizes of the pointwise multiplier, included by every file that needs a width or depth
`ifndef PWM_CONFIG_SVH
`define PWM_CONFIG_SVH

// ========================================
// arithmetic
// ========================================

// modulus q = 2^23 - 2^13 + 1
`define PWM_Q 23'd8380417
`define PWM_COEFF_W 23

// ========================================
// polynomial and memory geometry
// ========================================

// coefficients per polynomial and the index that counts them
`define PWM_N 256
`define PWM_IDX_W 8
// the top address bit picks one of the two banks
`define PWM_ADDR_W 9

// ========================================
// flow control
// ========================================

// input queue depth, also the producer's starting credit count
`define PWM_IN_DEPTH 4
// credits the output side holds toward the consumer after reset
`define PWM_OUT_CREDITS 4

`endif

/* logic/pwm_pkg.sv */
// beat and tag types of the pointwise multiplier, shared by the RTL and the testbench
`include "pwm_config.svh"

package pwm_pkg;

    // one input beat, the two coefficients to be multiplied
    typedef struct packed {
        logic [`PWM_COEFF_W-1:0] a;
        logic [`PWM_COEFF_W-1:0] b;
    } pair_t;

    // a pair on its way into the multiplier, with the bank and slot it will land in
    typedef struct packed {
        logic                  bank;
        logic [`PWM_IDX_W-1:0] idx;
        pair_t                 pair;
    } tagged_t;

    // a reduced product heading for memory port A
    typedef struct packed {
        logic                    bank;
        logic [`PWM_IDX_W-1:0]   idx;
        logic [`PWM_COEFF_W-1:0] coeff;
    } result_t;

    // one output beat toward the consumer
    typedef struct packed {
        logic [`PWM_IDX_W-1:0]   idx;
        logic [`PWM_COEFF_W-1:0] coeff;
    } out_beat_t;

endpackage

/* logic/pwm_in_port.sv */
// input side; queues credit-flowed coefficient pairs and releases them, tagged, into a free bank
`include "pwm_config.svh"

module pwm_in_port (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize,
    input  logic             in_valid,
    input  pwm_pkg::pair_t   in_beat,
    output logic             in_credit,
    output logic             mul_valid,
    output pwm_pkg::tagged_t mul_tag,
    input  logic             bank_release,
    input  logic             rel_bank
);

    localparam int DEPTH = `PWM_IN_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [`PWM_IDX_W-1:0] LAST_IDX = `PWM_IDX_W'(`PWM_N - 1);

    pwm_pkg::pair_t        queue [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [`PWM_IDX_W-1:0] idx;
    logic                  wr_bank;
    logic [1:0]            busy;
    logic                  release_head;

    // the head leaves only when the bank it would fill has been drained
    assign release_head = (count != '0) && !busy[wr_bank];

    // ========================================
    // queue storage and pointers
    // ========================================

    // entries are only read behind the count, so the storage needs no clear
    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (zeroize) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (release_head) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(in_valid) - CNT_W'(release_head);
        end
    end

    // ========================================
    // tagging and bank ownership
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idx       <= '0;
            wr_bank   <= 1'b0;
            busy      <= '0;
            mul_valid <= 1'b0;
            in_credit <= 1'b0;
        end else if (zeroize) begin
            idx       <= '0;
            wr_bank   <= 1'b0;
            busy      <= '0;
            mul_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            // each released entry frees one slot, which goes back as one credit
            mul_valid <= release_head;
            in_credit <= release_head;
            // the drained bank is never the one being filled, so the two updates never collide
            if (bank_release) begin
                busy[rel_bank] <= 1'b0;
            end
            if (release_head) begin
                idx <= idx + 1'b1;
                // the last coefficient closes the block and the next one goes to the other bank
                if (idx == LAST_IDX) begin
                    busy[wr_bank] <= 1'b1;
                    wr_bank       <= ~wr_bank;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (release_head) begin
            mul_tag <= '{bank: wr_bank, idx: idx, pair: queue[rd_ptr]};
        end
    end

    // a producer that honours its credits can never find the queue full
    a_no_overrun: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        in_valid |-> (count < CNT_W'(DEPTH)));

endmodule

/* logic/pwm_mod_mul.sv */
// three-stage modular multiplier for q = 2^23 - 2^13 + 1, carrying the bank and index tag along
`include "pwm_config.svh"

module pwm_mod_mul (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize,
    input  logic             mul_valid,
    input  pwm_pkg::tagged_t mul_tag,
    output logic             res_valid,
    output pwm_pkg::result_t res,
    output logic             block_done,
    output logic             block_bank
);

    localparam int CW = `PWM_COEFF_W;
    localparam logic [CW-1:0] Q = `PWM_Q;
    localparam logic [`PWM_IDX_W-1:0] LAST_IDX = `PWM_IDX_W'(`PWM_N - 1);

    // stage 1 holds the full product
    logic                  v1;
    logic                  bank1;
    logic [`PWM_IDX_W-1:0] idx1;
    logic [2*CW-1:0]       prod1;
    // stage 2 holds the product after two folds
    logic                  v2;
    logic                  bank2;
    logic [`PWM_IDX_W-1:0] idx2;
    logic [27:0]           fold2;
    // combinational reduction between the registers
    logic [36:0]           fold1_c;
    logic [27:0]           fold2_c;
    logic [23:0]           fold3_c;
    logic [24:0]           sub1_c;
    logic [24:0]           sub2_c;
    logic [CW-1:0]         reduced_c;

    // ========================================
    // folding reduction
    // ========================================

    // 2^23 is congruent to 2^13 - 1, so hi * 2^23 + lo folds to lo + (hi << 13) - hi
    // and the subtraction never underflows because hi << 13 is at least hi
    assign fold1_c = 37'(prod1[CW-1:0]) + (37'(prod1[2*CW-1:CW]) << 13)
                   - 37'(prod1[2*CW-1:CW]);
    // the second fold brings the 37-bit value below 2^28
    assign fold2_c = 28'(fold1_c[CW-1:0]) + (28'(fold1_c[36:CW]) << 13)
                   - 28'(fold1_c[36:CW]);
    // the third fold leaves only five high bits to absorb, ending below 2q
    assign fold3_c = 24'(fold2[CW-1:0]) + (24'(fold2[27:CW]) << 13) - 24'(fold2[27:CW]);

    // a clear top bit means the subtraction did not borrow
    assign sub1_c = {1'b0, fold3_c} - 25'(Q);
    assign sub2_c = {1'b0, fold3_c} - {1'b0, Q, 1'b0};

    always_comb begin
        if (!sub2_c[24]) begin
            reduced_c = sub2_c[CW-1:0];
        end else if (!sub1_c[24]) begin
            reduced_c = sub1_c[CW-1:0];
        end else begin
            reduced_c = fold3_c[CW-1:0];
        end
    end

    // ========================================
    // pipeline registers
    // ========================================

    // only the valids and the block pulse carry a reset, the data follows them
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            v1         <= 1'b0;
            v2         <= 1'b0;
            res_valid  <= 1'b0;
            block_done <= 1'b0;
        end else if (zeroize) begin
            v1         <= 1'b0;
            v2         <= 1'b0;
            res_valid  <= 1'b0;
            block_done <= 1'b0;
        end else begin
            v1         <= mul_valid;
            v2         <= v1;
            res_valid  <= v2;
            block_done <= v2 && (idx2 == LAST_IDX);
        end
    end

    always_ff @(posedge clk) begin
        bank1 <= mul_tag.bank;
        idx1  <= mul_tag.idx;
        prod1 <= mul_tag.pair.a * mul_tag.pair.b;
        bank2 <= bank1;
        idx2  <= idx1;
        fold2 <= fold2_c;
        res   <= '{bank: bank2, idx: idx2, coeff: reduced_c};
    end

    // the bank of the closing result is the bank that became full
    assign block_bank = res.bank;

    // the three folds and two subtractions together must land fully reduced
    a_reduced: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        res_valid |-> (res.coeff < Q));

endmodule

/* logic/pwm_ram_tdp.sv */
// two-bank coefficient memory; port A writes products, port B reads them out registered
`include "pwm_config.svh"

module pwm_ram_tdp #(
    parameter int ADDR_W = `PWM_ADDR_W,
    parameter int DATA_W = `PWM_COEFF_W
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize,
    input  logic              ena,
    input  logic              wea,
    input  logic [ADDR_W-1:0] addra,
    input  logic [DATA_W-1:0] dina,
    input  logic              enb,
    input  logic [ADDR_W-1:0] addrb,
    output logic [DATA_W-1:0] doutb
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    // ========================================
    // port B read
    // ========================================

    // read data shows up one cycle after enb and is wiped with the array
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            doutb <= '0;
        end else if (zeroize) begin
            doutb <= '0;
        end else if (enb) begin
            doutb <= mem[addrb];
        end
    end

    // ========================================
    // port A write
    // ========================================

    // secret coefficients must not survive a zeroize, so every word is cleared
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (ena && wea) begin
            mem[addra] <= dina;
        end
    end

    // the input side fills one bank while the output side drains the other
    a_bank_split: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        (ena && wea && enb) |-> (addra[ADDR_W-1] != addrb[ADDR_W-1]));

endmodule

/* logic/pwm_out_port.sv */
// output side; drains finished banks in index order under consumer credits and frees them
`include "pwm_config.svh"

module pwm_out_port (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    block_done,
    input  logic                    block_bank,
    output logic                    enb,
    output logic [`PWM_ADDR_W-1:0]  addrb,
    input  logic [`PWM_COEFF_W-1:0] doutb,
    output logic                    out_valid,
    output pwm_pkg::out_beat_t      out_beat,
    input  logic                    out_credit,
    output logic                    bank_release,
    output logic                    rel_bank
);

    localparam int CRED = `PWM_OUT_CREDITS;
    localparam int CRED_W = $clog2(CRED + 1);
    localparam logic [`PWM_IDX_W-1:0] LAST_IDX = `PWM_IDX_W'(`PWM_N - 1);

    logic [1:0]            full;
    logic                  rd_bank;
    logic [`PWM_IDX_W-1:0] rd_idx;
    logic [CRED_W-1:0]     credit_cnt;
    logic                  rd_v1;
    logic [`PWM_IDX_W-1:0] idx1;
    logic                  last_read;

    // one read per cycle while the current bank is full and a credit is left
    assign enb       = full[rd_bank] && (credit_cnt != '0);
    assign addrb     = {rd_bank, rd_idx};
    assign last_read = enb && (rd_idx == LAST_IDX);

    // ========================================
    // bank sequencing and credits
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full         <= '0;
            rd_bank      <= 1'b0;
            rd_idx       <= '0;
            credit_cnt   <= CRED_W'(CRED);
            bank_release <= 1'b0;
            rel_bank     <= 1'b0;
        end else if (zeroize) begin
            full         <= '0;
            rd_bank      <= 1'b0;
            rd_idx       <= '0;
            credit_cnt   <= CRED_W'(CRED);
            bank_release <= 1'b0;
            rel_bank     <= 1'b0;
        end else begin
            // a credit is spent when the read goes out, not when the beat leaves
            credit_cnt   <= credit_cnt - CRED_W'(enb) + CRED_W'(out_credit);
            bank_release <= last_read;
            rel_bank     <= rd_bank;
            if (enb) begin
                rd_idx <= rd_idx + 1'b1;
            end
            // banks fill alternately, so toggling the read bank keeps completion order
            if (last_read) begin
                full[rd_bank] <= 1'b0;
                rd_bank       <= ~rd_bank;
            end
            if (block_done) begin
                full[block_bank] <= 1'b1;
            end
        end
    end

    // ========================================
    // read stage and output beat
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_v1     <= 1'b0;
            out_valid <= 1'b0;
        end else if (zeroize) begin
            rd_v1     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rd_v1     <= enb;
            out_valid <= rd_v1;
        end
    end

    // the index waits one cycle so it meets the memory data
    always_ff @(posedge clk) begin
        idx1     <= rd_idx;
        out_beat <= '{idx: idx1, coeff: doutb};
    end

    // a beat on the wire was paid with a credit that the consumer has not handed back yet
    a_credit_held: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        out_valid |-> (credit_cnt < CRED_W'(CRED)));

endmodule

/* logic/pwm_top.sv */
// top of the pointwise multiplier; connects input side, multiplier, bank memory and output side
`include "pwm_config.svh"

module pwm_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize,
    input  logic               in_valid,
    input  pwm_pkg::pair_t     in_beat,
    output logic               in_credit,
    output logic               out_valid,
    output pwm_pkg::out_beat_t out_beat,
    input  logic               out_credit
);

    // ========================================
    // internal links
    // ========================================

    // input side to multiplier
    logic                    mul_valid;
    pwm_pkg::tagged_t        mul_tag;
    // multiplier to memory port A and block completion
    logic                    res_valid;
    pwm_pkg::result_t        res;
    logic                    block_done;
    logic                    block_bank;
    // memory port B
    logic                    enb;
    logic [`PWM_ADDR_W-1:0]  addrb;
    logic [`PWM_COEFF_W-1:0] doutb;
    // bank handback from output side to input side
    logic                    bank_release;
    logic                    rel_bank;

    pwm_in_port in_port0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .in_credit    (in_credit),
        .mul_valid    (mul_valid),
        .mul_tag      (mul_tag),
        .bank_release (bank_release),
        .rel_bank     (rel_bank)
    );

    pwm_mod_mul mod_mul0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .mul_valid  (mul_valid),
        .mul_tag    (mul_tag),
        .res_valid  (res_valid),
        .res        (res),
        .block_done (block_done),
        .block_bank (block_bank)
    );

    // the bank bit sits above the index to form the write address
    pwm_ram_tdp #(
        .ADDR_W (`PWM_ADDR_W),
        .DATA_W (`PWM_COEFF_W)
    ) ram0 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .ena     (res_valid),
        .wea     (res_valid),
        .addra   ({res.bank, res.idx}),
        .dina    (res.coeff),
        .enb     (enb),
        .addrb   (addrb),
        .doutb   (doutb)
    );

    pwm_out_port out_port0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .block_done   (block_done),
        .block_bank   (block_bank),
        .enb          (enb),
        .addrb        (addrb),
        .doutb        (doutb),
        .out_valid    (out_valid),
        .out_beat     (out_beat),
        .out_credit   (out_credit),
        .bank_release (bank_release),
        .rel_bank     (rel_bank)
    );

endmodule

/* sim/pwm_tb.sv */
// self-checking testbench for pwm_top; random credit-flowed pairs against a modular product model
`include "pwm_config.svh"

module pwm_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = `PWM_N;
    localparam int IN_DEPTH = `PWM_IN_DEPTH;
    localparam int OUT_CREDITS = `PWM_OUT_CREDITS;
    localparam longint unsigned Q = `PWM_Q;
    localparam int unsigned Q_MAX = `PWM_Q - 1;
    // one edge block, six back to back, a partial block and one after zeroize
    localparam int NUM_BLOCKS = 9;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * N * 40;
    localparam int DRAIN_LIMIT = 6 * N * 40;

    logic               clk;
    logic               reset_n;
    logic               zeroize;
    logic               in_valid;
    pwm_pkg::pair_t     in_beat;
    logic               in_credit;
    logic               out_valid;
    pwm_pkg::out_beat_t out_beat;
    logic               out_credit;

    pwm_pkg::out_beat_t exp_q[$];
    pwm_pkg::out_beat_t expected;
    logic [`PWM_IDX_W-1:0] model_idx;
    int prod_credits = IN_DEPTH;
    int total_sent = 0;
    int epoch_sent = 0;
    int credit_pulses = 0;
    int beats_out = 0;
    int returned = 0;
    int owed = 0;
    int checked = 0;
    int value_errors = 0;
    int protocol_errors = 0;
    int slow_max = 2;
    int wait_cnt = 0;
    bit hold = 1'b0;

    pwm_top dut0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // model and checks
    // ========================================

    // a*b mod q in 64-bit arithmetic, straight from the definition
    function automatic logic [`PWM_COEFF_W-1:0] expected_product(input logic [22:0] a,
                                                                 input logic [22:0] b);
        longint unsigned wide_a;
        wide_a = a;
        return `PWM_COEFF_W'((wide_a * b) % Q);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        protocol_errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // monitor of credits and beats, half a cycle after the DUT registers move
    always @(negedge clk) begin
        if (reset_n) begin
            if (total_sent == 0 && (in_credit || out_valid)) begin
                report_error("in_credit or out_valid went high before any input was sent");
            end
            if (in_credit) begin
                prod_credits++;
                credit_pulses++;
                if (credit_pulses > epoch_sent) begin
                    report_error("more in_credit pulses than beats sent");
                end
                if (prod_credits > IN_DEPTH) begin
                    report_error("producer credits rose above the input queue depth");
                end
            end
            if (out_valid) begin
                beats_out++;
                owed++;
                if (beats_out > OUT_CREDITS + returned) begin
                    report_error("out_valid beat sent without a consumer credit");
                end
                if (exp_q.size() == 0) begin
                    report_error("output beat arrived with no beat expected");
                end else begin
                    expected = exp_q.pop_front();
                    check_value("out_beat.idx", 32'(out_beat.idx), 32'(expected.idx));
                    check_value("out_beat.coeff", 32'(out_beat.coeff), 32'(expected.coeff));
                    checked++;
                end
            end
            // zeroize wipes the DUT, so both sides start over with full credits
            if (zeroize) begin
                exp_q.delete();
                model_idx = '0;
                prod_credits = IN_DEPTH;
                epoch_sent = 0;
                credit_pulses = 0;
                beats_out = 0;
                returned = 0;
                owed = 0;
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================

    // consumer hands back one credit per received beat after a random delay
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else if (owed > 0 && !hold) begin
                out_credit = 1'b1;
                owed--;
                returned++;
                wait_cnt = $urandom_range(slow_max, 0);
            end
        end
    end

    // sends pairs under producer credits; the first six of an edge block are fixed corner cases
    task automatic send_beats(input int count, input int max_gap, input bit edges);
        pwm_pkg::pair_t pair;
        pwm_pkg::out_beat_t beat;
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = (max_gap == 0) ? 0 : $urandom_range(max_gap, 0);
            repeat (gap) begin
                @(posedge clk);
                #1;
                in_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            while (prod_credits == 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            pair.a = 23'($urandom_range(Q_MAX, 0));
            pair.b = 23'($urandom_range(Q_MAX, 0));
            if (edges && i < 6) begin
                case (i)
                    0: pair.a = '0;
                    1: pair.b = '0;
                    2: pair.a = 23'd1;
                    3: pair.b = 23'd1;
                    4: pair = '{a: 23'(Q_MAX), b: 23'(Q_MAX)};
                    default: pair = '{a: 23'(Q_MAX), b: 23'd1};
                endcase
            end
            in_valid = 1'b1;
            in_beat = pair;
            prod_credits--;
            total_sent++;
            epoch_sent++;
            beat.idx = model_idx;
            beat.coeff = expected_product(pair.a, pair.b);
            exp_q.push_back(beat);
            model_idx++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            report_error("expected beats never came out of the DUT");
        end
        // a quiet tail shows up any repeated or stray beat
        repeat (40) @(posedge clk);
        #1;
        check_value("producer credits", 32'(prod_credits), 32'(IN_DEPTH));
    endtask

    initial begin
        void'($urandom(32'hf974));
        reset_n = 1'b0;
        zeroize = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        model_idx = '0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;
        // nothing may come out during the idle window
        repeat (20) @(posedge clk);
        #1;
        send_beats(N, 2, 1'b1);
        wait_drain();
        // six blocks with a slow consumer that also withholds credits for a while
        slow_max = 12;
        fork
            send_beats(6 * N, 0, 1'b0);
            begin
                repeat (300) @(posedge clk);
                hold = 1'b1;
                repeat (600) @(posedge clk);
                hold = 1'b0;
            end
        join
        wait_drain();
        slow_max = 2;
        // part of a block goes in, then zeroize drops it
        send_beats(100, 1, 1'b0);
        repeat (10) @(posedge clk);
        #1;
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        send_beats(N, 2, 1'b0);
        wait_drain();
        $display("errors: %0d value mismatches, %0d protocol errors, %0d beats checked",
                 value_errors, protocol_errors, checked);
        if (value_errors + protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ========================================
    // watchdog
    // ========================================

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* files.f */
+incdir+logic
logic/pwm_pkg.sv
logic/pwm_in_port.sv
logic/pwm_mod_mul.sv
logic/pwm_ram_tdp.sv
logic/pwm_out_port.sv
logic/pwm_top.sv
sim/pwm_tb.sv
